// ==== flist.f ====
amo_pkg.sv
tcdm_req_ctrl.sv
lrsc_monitor.sv
amo_alu.sv
tcdm_resp_buffer.sv
tcdm_adapter.sv
tcdm_adapter_asserts.sv
tb_clkgen.sv
tb_tcdm_adapter.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_tcdm_adapter

out=$(./obj_dir/Vtb_tcdm_adapter)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== tb_tcdm_adapter.sv ====
module tb_tcdm_adapter import amo_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // tests need about 400 cycles
  localparam int max_cycles    = 3000;
  localparam int accept_max    = 40;
  localparam int resp_wait_max = 20;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid_i;
  logic                  in_ready_o;
  logic [addr_width-1:0] in_addr_i;
  logic [3:0]            in_amo_i;
  logic                  in_write_i;
  logic [data_width-1:0] in_wdata_i;
  logic [be_width-1:0]   in_be_i;
  logic [meta_width-1:0] in_meta_i;
  logic                  in_valid_o;
  logic                  in_ready_i;
  logic [data_width-1:0] in_rdata_o;
  logic [meta_width-1:0] in_meta_o;
  logic                  out_req_o;
  logic [addr_width-1:0] out_addr_o;
  logic                  out_write_o;
  logic [data_width-1:0] out_wdata_o;
  logic [be_width-1:0]   out_be_o;
  logic [data_width-1:0] out_rdata_i;

  logic [data_width-1:0] sram [256];
  logic [data_width-1:0] resp_data_q [$];
  logic [meta_width-1:0] resp_meta_q [$];
  logic [31:0]           lfsr_state;
  string                 cur_test;
  int                    test_errs;
  int                    total_errs;
  int                    tests_run;
  int                    tests_failed;
  int                    cycles;

  tb_clkgen i_clkgen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  tcdm_adapter dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_addr_i  (in_addr_i),
    .in_amo_i   (in_amo_i),
    .in_write_i (in_write_i),
    .in_wdata_i (in_wdata_i),
    .in_be_i    (in_be_i),
    .in_meta_i  (in_meta_i),
    .in_valid_o (in_valid_o),
    .in_ready_i (in_ready_i),
    .in_rdata_o (in_rdata_o),
    .in_meta_o  (in_meta_o),
    .out_req_o  (out_req_o),
    .out_addr_o (out_addr_o),
    .out_write_o(out_write_o),
    .out_wdata_o(out_wdata_o),
    .out_be_o   (out_be_o),
    .out_rdata_i(out_rdata_i)
  );

  // --------------------
  // sram model
  // --------------------

  // word index from byte address, read data one cycle later
  initial begin
    for (int i = 0; i < 256; i++) begin
      sram[i] = (32'(i) << 2) ^ 32'h5a3c_0000;
    end
    out_rdata_i = '0;
    forever begin
      @(posedge clk);
      if (out_req_o && out_write_o) begin
        for (int b = 0; b < be_width; b++) begin
          if (out_be_o[b]) sram[out_addr_o[9:2]][8*b +: 8] = out_wdata_o[8*b +: 8];
        end
      end else if (out_req_o) begin
        out_rdata_i <= sram[out_addr_o[9:2]];
      end
    end
  end

  // responses taken late in the cycle, well clear of both edges
  always begin
    @(negedge clk);
    #40;
    if (in_valid_o && in_ready_i) begin
      resp_data_q.push_back(in_rdata_o);
      resp_meta_q.push_back(in_meta_o);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not end within %0d cycles", max_cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // --------------------
  // helpers
  // --------------------

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic logic [meta_width-1:0] make_meta(logic [2:0] core, logic [2:0] txn);
    return {core, txn};
  endfunction

  // new memory word after an atomic
  function automatic logic [31:0] amo_expect(amo_op_e op, logic [31:0] old, logic [31:0] opnd);
    case (op)
      amo_swap: return opnd;
      amo_add:  return old + opnd;
      amo_and:  return old & opnd;
      amo_or:   return old | opnd;
      amo_xor:  return old ^ opnd;
      amo_max:  return ($signed(old) > $signed(opnd)) ? old : opnd;
      amo_maxu: return (old > opnd) ? old : opnd;
      amo_min:  return ($signed(old) < $signed(opnd)) ? old : opnd;
      amo_minu: return (old < opnd) ? old : opnd;
      default:  return old;
    endcase
  endfunction

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_req(logic [31:0] addr, amo_op_e op, logic wr, logic [31:0] data,
                          logic [3:0] be, logic [meta_width-1:0] meta);
    int  waited;
    logic taken;
    waited     = 0;
    taken      = 1'b0;
    in_valid_i = 1'b1;
    in_addr_i  = addr;
    in_amo_i   = op;
    in_write_i = wr;
    in_wdata_i = data;
    in_be_i    = be;
    in_meta_i  = meta;
    while (!taken && waited < accept_max) begin
      #10;
      taken = in_ready_o;
      @(negedge clk);
      waited++;
    end
    if (!taken) begin
      $display("%s: request to %h was never accepted", cur_test, addr);
      test_errs++;
    end
    in_valid_i = 1'b0;
  endtask

  task automatic expect_resp(string what, logic [31:0] exp_data, logic [meta_width-1:0] exp_meta);
    logic [31:0]           got_data;
    logic [meta_width-1:0] got_meta;
    int                    waited;
    waited = 0;
    while (resp_data_q.size() == 0) begin
      if (waited >= resp_wait_max) begin
        $display("%s %s: no response arrived", cur_test, what);
        test_errs++;
        return;
      end
      @(negedge clk);
      waited++;
    end
    got_data = resp_data_q.pop_front();
    got_meta = resp_meta_q.pop_front();
    if (got_data !== exp_data) begin
      $display("ERROR %s %s data: expected %h, actual %h", cur_test, what, exp_data, got_data);
      test_errs++;
    end
    if (got_meta !== exp_meta) begin
      $display("ERROR %s %s meta: expected %h, actual %h", cur_test, what, exp_meta, got_meta);
      test_errs++;
    end
  endtask

  task automatic start_test(string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    if (resp_data_q.size() != 0) begin
      $display("%s: %0d responses nobody asked for", cur_test, resp_data_q.size());
      test_errs++;
      resp_data_q.delete();
      resp_meta_q.delete();
    end
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, test_errs);
      tests_failed++;
    end
  endtask

  // --------------------
  // tests
  // --------------------

  task automatic reset_and_store_load();
    start_test("reset_and_store_load");
    #10;
    if (in_valid_o !== 1'b0) begin
      $display("ERROR %s in_valid_o: expected 0, actual %b", cur_test, in_valid_o);
      test_errs++;
    end
    if (out_req_o !== 1'b0) begin
      $display("ERROR %s out_req_o: expected 0, actual %b", cur_test, out_req_o);
      test_errs++;
    end
    if (in_ready_o !== 1'b1) begin
      $display("ERROR %s in_ready_o: expected 1, actual %b", cur_test, in_ready_o);
      test_errs++;
    end
    @(negedge clk);
    // a stray store response would show up first with the wrong tag
    send_req(32'h10, amo_none, 1'b1, 32'hcafe_f00d, 4'hf, make_meta(3'd0, 3'd1));
    send_req(32'h10, amo_none, 1'b0, '0, 4'hf, make_meta(3'd0, 3'd2));
    expect_resp("load", 32'hcafe_f00d, make_meta(3'd0, 3'd2));
    // bytes 0 and 2 only
    send_req(32'h10, amo_none, 1'b1, 32'h1234_5678, 4'h5, make_meta(3'd0, 3'd3));
    send_req(32'h10, amo_none, 1'b0, '0, 4'hf, make_meta(3'd0, 3'd4));
    expect_resp("masked load", 32'hca34_f078, make_meta(3'd0, 3'd4));
    finish_test();
  endtask

  task automatic atomic_ops();
    amo_op_e     rmw_ops [9];
    logic [31:0] old_word;
    logic [31:0] operand;
    logic [31:0] addr;
    rmw_ops = '{amo_swap, amo_add, amo_and, amo_or, amo_xor,
                amo_max, amo_maxu, amo_min, amo_minu};
    start_test("atomic_ops");
    for (int i = 0; i < 9; i++) begin
      old_word = rand_word();
      operand  = rand_word();
      addr     = 32'h100 + 32'(4 * i);
      send_req(addr, amo_none, 1'b1, old_word, 4'hf, make_meta(3'd2, 3'd0));
      send_req(addr, rmw_ops[i], 1'b0, operand, 4'hf, make_meta(3'd2, 3'(i)));
      expect_resp(rmw_ops[i].name(), old_word, make_meta(3'd2, 3'(i)));
      send_req(addr, amo_none, 1'b0, '0, 4'hf, make_meta(3'd2, 3'd7));
      expect_resp("reload", amo_expect(rmw_ops[i], old_word, operand), make_meta(3'd2, 3'd7));
    end
    finish_test();
  endtask

  task automatic lr_sc_same_core();
    start_test("lr_sc_same_core");
    send_req(32'h280, amo_none, 1'b1, 32'h1234_5678, 4'hf, make_meta(3'd0, 3'd0));
    send_req(32'h280, amo_lr, 1'b0, '0, 4'hf, make_meta(3'd0, 3'd1));
    expect_resp("lr", 32'h1234_5678, make_meta(3'd0, 3'd1));
    send_req(32'h280, amo_sc, 1'b1, 32'h8765_4321, 4'hf, make_meta(3'd0, 3'd2));
    expect_resp("sc", 32'd0, make_meta(3'd0, 3'd2));
    send_req(32'h280, amo_none, 1'b0, '0, 4'hf, make_meta(3'd0, 3'd3));
    expect_resp("load", 32'h8765_4321, make_meta(3'd0, 3'd3));
    finish_test();
  endtask

  task automatic sc_after_foreign_store();
    start_test("sc_after_foreign_store");
    send_req(32'h300, amo_none, 1'b1, 32'h0bad_0001, 4'hf, make_meta(3'd1, 3'd0));
    send_req(32'h300, amo_lr, 1'b0, '0, 4'hf, make_meta(3'd1, 3'd1));
    expect_resp("lr", 32'h0bad_0001, make_meta(3'd1, 3'd1));
    // core 2 breaks the reservation
    send_req(32'h300, amo_none, 1'b1, 32'h0bad_0002, 4'hf, make_meta(3'd2, 3'd0));
    send_req(32'h300, amo_sc, 1'b1, 32'h0bad_0003, 4'hf, make_meta(3'd1, 3'd2));
    expect_resp("sc", 32'd1, make_meta(3'd1, 3'd2));
    send_req(32'h300, amo_none, 1'b0, '0, 4'hf, make_meta(3'd1, 3'd3));
    expect_resp("load", 32'h0bad_0002, make_meta(3'd1, 3'd3));
    send_req(32'h300, amo_sc, 1'b1, 32'h0bad_0004, 4'hf, make_meta(3'd1, 3'd4));
    expect_resp("second sc", 32'd1, make_meta(3'd1, 3'd4));
    send_req(32'h300, amo_none, 1'b0, '0, 4'hf, make_meta(3'd1, 3'd5));
    expect_resp("second load", 32'h0bad_0002, make_meta(3'd1, 3'd5));
    finish_test();
  endtask

  task automatic response_backpressure();
    start_test("response_backpressure");
    for (int i = 0; i < 3; i++) begin
      send_req(32'h200 + 32'(4 * i), amo_none, 1'b1, 32'hd00d_0000 + 32'(i), 4'hf,
               make_meta(3'd3, 3'd0));
    end
    in_ready_i = 1'b0;
    fork
      begin
        for (int i = 0; i < 3; i++) begin
          send_req(32'h200 + 32'(4 * i), amo_none, 1'b0, '0, 4'hf, make_meta(3'd3, 3'(i + 1)));
        end
      end
      begin
        // first response is held, the later loads must wait
        repeat (4) @(negedge clk);
        #10;
        if (!in_valid_o || in_ready_o) begin
          $display("%s: in_ready_o did not fall while a response was held", cur_test);
          test_errs++;
        end
        @(negedge clk);
        in_ready_i = 1'b1;
      end
    join
    for (int i = 0; i < 3; i++) begin
      expect_resp("load", 32'hd00d_0000 + 32'(i), make_meta(3'd3, 3'(i + 1)));
    end
    finish_test();
  endtask

  // --------------------
  // sequence
  // --------------------

  initial begin
    in_valid_i   = 1'b0;
    in_addr_i    = '0;
    in_amo_i     = '0;
    in_write_i   = 1'b0;
    in_wdata_i   = '0;
    in_be_i      = '0;
    in_meta_i    = '0;
    in_ready_i   = 1'b1;
    lfsr_state   = 32'hbe3f903b;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    @(posedge rst_n);
    @(negedge clk);
    reset_and_store_load();
    atomic_ops();
    lr_sc_same_core();
    sc_after_foreign_store();
    response_backpressure();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tb_clkgen.sv ====
module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset held for two rising edges, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== tcdm_adapter_asserts.sv ====
module tcdm_adapter_asserts import amo_pkg::*; (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  in_valid_i,
  input logic                  in_ready_o,
  input logic [3:0]            in_amo_i,
  input logic                  in_valid_o,
  input logic                  in_ready_i,
  input logic [data_width-1:0] in_rdata_o,
  input logic [meta_width-1:0] in_meta_o,
  input logic                  out_req_o,
  input logic                  out_write_o,
  input logic [be_width-1:0]   out_be_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // read-modify-write accepted this cycle
  logic rmw_accept;

  assign rmw_accept = in_valid_i && in_ready_o && (in_amo_i >= amo_swap) && (in_amo_i <= amo_minu);

  // --------------------
  // response side
  // --------------------

  // a stalled response keeps its data and tag
  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_o && !in_ready_i |=> in_valid_o && $stable(in_rdata_o) && $stable(in_meta_o))
    else $error("response changed while stalled");

  // --------------------
  // atomic write-back
  // --------------------

  amo_write_back: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rmw_accept |=> out_req_o && out_write_o && (out_be_o == be_full))
    else $error("atomic not followed by full write-back");

  // core port closed while the bank is busy
  amo_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rmw_accept |=> !in_ready_o)
    else $error("in_ready_o high during write-back");

endmodule

bind tcdm_adapter tcdm_adapter_asserts i_asserts (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .in_valid_i (in_valid_i),
  .in_ready_o (in_ready_o),
  .in_amo_i   (in_amo_i),
  .in_valid_o (in_valid_o),
  .in_ready_i (in_ready_i),
  .in_rdata_o (in_rdata_o),
  .in_meta_o  (in_meta_o),
  .out_req_o  (out_req_o),
  .out_write_o(out_write_o),
  .out_be_o   (out_be_o)
);

// ==== tcdm_adapter.sv ====
module tcdm_adapter import amo_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // core request
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [addr_width-1:0] in_addr_i,
  input  logic [3:0]            in_amo_i,
  input  logic                  in_write_i,
  input  logic [data_width-1:0] in_wdata_i,
  input  logic [be_width-1:0]   in_be_i,
  input  logic [meta_width-1:0] in_meta_i,
  // core response
  output logic                  in_valid_o,
  input  logic                  in_ready_i,
  output logic [data_width-1:0] in_rdata_o,
  output logic [meta_width-1:0] in_meta_o,
  // sram bank
  output logic                  out_req_o,
  output logic [addr_width-1:0] out_addr_o,
  output logic                  out_write_o,
  output logic [data_width-1:0] out_wdata_o,
  output logic [be_width-1:0]   out_be_o,
  input  logic [data_width-1:0] out_rdata_i
);

  logic                  req_accept;
  logic                  resp_expect;
  logic                  is_sc;
  logic                  sc_success;
  logic                  resp_hold;
  amo_op_e               amo_op;
  logic [data_width-1:0] amo_operand;
  logic [data_width-1:0] amo_result;

  // --------------------
  // request path
  // --------------------

  tcdm_req_ctrl i_req_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_addr_i    (in_addr_i),
    .in_amo_i     (in_amo_i),
    .in_write_i   (in_write_i),
    .in_wdata_i   (in_wdata_i),
    .in_be_i      (in_be_i),
    .in_ready_o   (in_ready_o),
    .resp_hold_i  (resp_hold),
    .sc_success_i (sc_success),
    .amo_result_i (amo_result),
    .req_accept_o (req_accept),
    .resp_expect_o(resp_expect),
    .is_sc_o      (is_sc),
    .out_req_o    (out_req_o),
    .out_addr_o   (out_addr_o),
    .out_write_o  (out_write_o),
    .out_wdata_o  (out_wdata_o),
    .out_be_o     (out_be_o),
    .amo_op_o     (amo_op),
    .amo_operand_o(amo_operand)
  );

  lrsc_monitor i_lrsc_monitor (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_accept_i(req_accept),
    .in_amo_i    (in_amo_i),
    .in_write_i  (in_write_i),
    .in_addr_i   (in_addr_i),
    .in_meta_i   (in_meta_i),
    .sc_success_o(sc_success)
  );

  // old word arrives from the bank in the write-back cycle
  amo_alu i_amo_alu (
    .amo_op_i    (amo_op),
    .mem_rdata_i (out_rdata_i),
    .operand_i   (amo_operand),
    .amo_result_o(amo_result)
  );

  // --------------------
  // response path
  // --------------------

  tcdm_resp_buffer i_resp_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_accept_i (req_accept),
    .resp_expect_i(resp_expect),
    .is_sc_i      (is_sc),
    .sc_success_i (sc_success),
    .in_meta_i    (in_meta_i),
    .out_rdata_i  (out_rdata_i),
    .in_valid_o   (in_valid_o),
    .in_ready_i   (in_ready_i),
    .in_rdata_o   (in_rdata_o),
    .in_meta_o    (in_meta_o),
    .resp_hold_o  (resp_hold)
  );

endmodule

// ==== tcdm_resp_buffer.sv ====
module tcdm_resp_buffer import amo_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // request side strobes
  input  logic                  req_accept_i,
  input  logic                  resp_expect_i,
  input  logic                  is_sc_i,
  input  logic                  sc_success_i,
  input  logic [meta_width-1:0] in_meta_i,
  // bank read data, one cycle after the read
  input  logic [data_width-1:0] out_rdata_i,
  // core response
  output logic                  in_valid_o,
  input  logic                  in_ready_i,
  output logic [data_width-1:0] in_rdata_o,
  output logic [meta_width-1:0] in_meta_o,
  output logic                  resp_hold_o
);

  // accepted last cycle
  logic push_q;
  logic sc_q;
  logic sc_ok_q;

  logic                  meta_push;
  logic                  pop;
  logic [data_width-1:0] resp_data;

  // two-entry queues, write pointers apart, read pointer shared
  logic                  meta_wr_q;
  logic                  data_wr_q;
  logic                  rd_q;
  logic [1:0]            meta_cnt_q;
  logic [1:0]            data_cnt_q;
  logic [meta_width-1:0] meta_mem [2];
  logic [data_width-1:0] data_mem [2];

  // metadata enters at acceptance, data one cycle later
  assign meta_push = req_accept_i && resp_expect_i;
  // sc reports 0 on success and 1 on failure
  assign resp_data = sc_q ? {{(data_width-1){1'b0}}, !sc_ok_q} : out_rdata_i;

  // --------------------
  // core side
  // --------------------

  // data counts as present when it is queued or arriving this cycle
  assign in_valid_o  = (meta_cnt_q != 2'd0) && ((data_cnt_q != 2'd0) || push_q);
  assign pop         = in_valid_o && in_ready_i;
  assign resp_hold_o = in_valid_o && !in_ready_i;
  assign in_meta_o   = meta_mem[rd_q];
  // empty data queue passes the arriving word straight through
  assign in_rdata_o  = (data_cnt_q == 2'd0) ? resp_data : data_mem[rd_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_q     <= 1'b0;
      sc_q       <= 1'b0;
      sc_ok_q    <= 1'b0;
      meta_wr_q  <= 1'b0;
      data_wr_q  <= 1'b0;
      rd_q       <= 1'b0;
      meta_cnt_q <= 2'd0;
      data_cnt_q <= 2'd0;
    end else begin
      push_q     <= meta_push;
      sc_q       <= req_accept_i && is_sc_i;
      sc_ok_q    <= sc_success_i;
      meta_wr_q  <= meta_wr_q ^ meta_push;
      data_wr_q  <= data_wr_q ^ push_q;
      rd_q       <= rd_q ^ pop;
      meta_cnt_q <= meta_cnt_q + 2'(meta_push) - 2'(pop);
      data_cnt_q <= data_cnt_q + 2'(push_q) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (meta_push) begin
      meta_mem[meta_wr_q] <= in_meta_i;
    end
    if (push_q) begin
      data_mem[data_wr_q] <= resp_data;
    end
  end

endmodule

// ==== amo_alu.sv ====
module amo_alu import amo_pkg::*; (
  input  amo_op_e               amo_op_i,
  input  logic [data_width-1:0] mem_rdata_i,
  input  logic [data_width-1:0] operand_i,
  output logic [data_width-1:0] amo_result_o
);

  // shared adder, one bit wider for the compare sign
  logic [data_width:0] add_a;
  logic [data_width:0] add_b;
  logic                add_cin;
  logic [data_width:0] add_sum;
  // memory word below operand
  logic                mem_lt;

  always_comb begin
    // plain add with sign-extended inputs
    add_a   = {mem_rdata_i[data_width-1], mem_rdata_i};
    add_b   = {operand_i[data_width-1], operand_i};
    add_cin = 1'b0;
    case (amo_op_i)
      amo_max, amo_min: begin
        // signed subtract, mem - operand
        add_b   = ~{operand_i[data_width-1], operand_i};
        add_cin = 1'b1;
      end
      amo_maxu, amo_minu: begin
        // unsigned subtract on zero-extended words
        add_a   = {1'b0, mem_rdata_i};
        add_b   = ~{1'b0, operand_i};
        add_cin = 1'b1;
      end
      default: ;
    endcase
  end

  assign add_sum = add_a + add_b + {{data_width{1'b0}}, add_cin};
  assign mem_lt  = add_sum[data_width];

  // --------------------
  // result select
  // --------------------

  always_comb begin
    case (amo_op_i)
      amo_swap: amo_result_o = operand_i;
      amo_add:  amo_result_o = add_sum[data_width-1:0];
      amo_and:  amo_result_o = mem_rdata_i & operand_i;
      amo_or:   amo_result_o = mem_rdata_i | operand_i;
      amo_xor:  amo_result_o = mem_rdata_i ^ operand_i;
      amo_max,
      amo_maxu: amo_result_o = mem_lt ? operand_i : mem_rdata_i;
      amo_min,
      amo_minu: amo_result_o = mem_lt ? mem_rdata_i : operand_i;
      // anything else leaves memory unchanged
      default:  amo_result_o = mem_rdata_i;
    endcase
  end

endmodule

// ==== lrsc_monitor.sv ====
module lrsc_monitor import amo_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_accept_i,
  input  logic [3:0]            in_amo_i,
  input  logic                  in_write_i,
  input  logic [addr_width-1:0] in_addr_i,
  input  logic [meta_width-1:0] in_meta_i,
  output logic                  sc_success_o
);

  // reservation, one for the whole bank
  logic                     resv_valid_q;
  logic [addr_width-1:0]    resv_addr_q;
  logic [core_id_width-1:0] resv_core_q;

  amo_op_e                  op;
  logic [core_id_width-1:0] core_id;
  logic                     own_core;
  logic                     addr_hit;
  logic                     is_lr;
  logic                     is_sc;
  logic                     mem_update;
  logic                     take_lr;
  logic                     disturb;
  logic                     sc_owner;

  assign op      = amo_op_e'(in_amo_i);
  // core id comes straight from the upper metadata bits
  assign core_id = in_meta_i[meta_width-1 -: core_id_width];

  assign own_core = (resv_core_q == core_id);
  assign addr_hit = (resv_addr_q == in_addr_i);
  assign is_lr    = (op == amo_lr);
  assign is_sc    = (op == amo_sc);

  // stores and atomics change memory behind the reservation
  assign mem_update = is_rmw(in_amo_i) || (in_write_i && !is_lr && !is_sc);

  // --------------------
  // reservation rules
  // --------------------

  // lr may only replace a reservation of its own core
  assign take_lr  = req_accept_i && is_lr && (!resv_valid_q || own_core);
  // write from someone else kills it
  assign disturb  = req_accept_i && resv_valid_q && !own_core && addr_hit && mem_update;
  // any sc of the owner consumes the reservation
  assign sc_owner = resv_valid_q && is_sc && own_core;

  assign sc_success_o = sc_owner && addr_hit;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resv_valid_q <= 1'b0;
    end else if (take_lr) begin
      resv_valid_q <= 1'b1;
    end else if (disturb || (req_accept_i && sc_owner)) begin
      resv_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_lr) begin
      resv_addr_q <= in_addr_i;
      resv_core_q <= core_id;
    end
  end

endmodule

// ==== tcdm_req_ctrl.sv ====
module tcdm_req_ctrl import amo_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // core request
  input  logic                  in_valid_i,
  input  logic [addr_width-1:0] in_addr_i,
  input  logic [3:0]            in_amo_i,
  input  logic                  in_write_i,
  input  logic [data_width-1:0] in_wdata_i,
  input  logic [be_width-1:0]   in_be_i,
  output logic                  in_ready_o,
  // feedback from response side, reservation and alu
  input  logic                  resp_hold_i,
  input  logic                  sc_success_i,
  input  logic [data_width-1:0] amo_result_i,
  // per-request strobes
  output logic                  req_accept_o,
  output logic                  resp_expect_o,
  output logic                  is_sc_o,
  // bank port
  output logic                  out_req_o,
  output logic [addr_width-1:0] out_addr_o,
  output logic                  out_write_o,
  output logic [data_width-1:0] out_wdata_o,
  output logic [be_width-1:0]   out_be_o,
  // latched atomic for the alu
  output amo_op_e               amo_op_o,
  output logic [data_width-1:0] amo_operand_o
);

  amo_state_e            state_q, state_d;
  amo_op_e               amo_op_q;
  logic [addr_width-1:0] addr_q;
  logic [data_width-1:0] operand_q;

  logic is_rmw_req;
  logic is_lr;
  logic is_store;
  logic load_amo;

  // --------------------
  // request decode
  // --------------------

  assign is_rmw_req = is_rmw(in_amo_i);
  assign is_lr      = (amo_op_e'(in_amo_i) == amo_lr);
  assign is_sc_o    = (amo_op_e'(in_amo_i) == amo_sc);
  // plain store, atomics and lr/sc win over the write flag
  assign is_store   = in_write_i && !is_rmw_req && !is_lr && !is_sc_o;

  // every non-store gets a response
  assign resp_expect_o = !is_store;

  // stall on a held response and while the bank is busy with a write-back
  assign in_ready_o   = !resp_hold_i && (state_q == idle);
  assign req_accept_o = in_valid_i && in_ready_o;
  assign load_amo     = req_accept_o && is_rmw_req;

  assign amo_op_o      = amo_op_q;
  assign amo_operand_o = operand_q;

  // --------------------
  // bank port and fsm
  // --------------------

  always_comb begin
    // default is pass-through of the core request
    state_d     = state_q;
    out_req_o   = req_accept_o;
    out_addr_o  = in_addr_i;
    // an sc only writes when the reservation holds
    out_write_o = is_store || (is_sc_o && sc_success_i);
    out_wdata_o = in_wdata_i;
    out_be_o    = in_be_i;

    case (state_q)
      idle: begin
        if (load_amo) begin
          state_d = write_back;
        end
      end
      write_back: begin
        // claim the bank for the new word
        out_req_o   = 1'b1;
        out_addr_o  = addr_q;
        out_write_o = 1'b1;
        out_wdata_o = amo_result_i;
        out_be_o    = be_full;
        state_d     = idle;
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= idle;
      amo_op_q <= amo_none;
    end else begin
      state_q <= state_d;
      if (load_amo) begin
        amo_op_q <= amo_op_e'(in_amo_i);
      end
    end
  end

  // address and operand of the pending atomic
  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      addr_q    <= in_addr_i;
      operand_q <= in_wdata_i;
    end
  end

endmodule

// ==== amo_pkg.sv ====
package amo_pkg;

  // --------------------
  // bus widths
  // --------------------

  localparam int unsigned addr_width = 32;
  // only 32-bit words are supported
  localparam int unsigned data_width = 32;
  localparam int unsigned be_width   = data_width / 8;

  // metadata tag, core id in the upper bits, transaction id below
  localparam int unsigned core_id_width = 3;
  localparam int unsigned txn_id_width  = 3;
  localparam int unsigned meta_width    = core_id_width + txn_id_width;

  // all bytes written on the atomic write-back
  localparam logic [be_width-1:0] be_full = '1;

  // --------------------
  // opcodes and states
  // --------------------

  // codes 12 to 15 are unused and behave like amo_none
  typedef enum logic [3:0] {
    amo_none = 4'h0,
    amo_swap = 4'h1,
    amo_add  = 4'h2,
    amo_and  = 4'h3,
    amo_or   = 4'h4,
    amo_xor  = 4'h5,
    amo_max  = 4'h6,
    amo_maxu = 4'h7,
    amo_min  = 4'h8,
    amo_minu = 4'h9,
    amo_lr   = 4'ha,
    amo_sc   = 4'hb
  } amo_op_e;

  // atomic sequencer, one extra cycle for the write-back
  typedef enum logic {
    idle       = 1'b0,
    write_back = 1'b1
  } amo_state_e;

  // read-modify-write opcodes, swap up to minu
  function automatic logic is_rmw(logic [3:0] op);
    return (op >= amo_swap) && (op <= amo_minu);
  endfunction

endpackage
